// ==== load_store_unit.f ====
logic/lsu_config_pkg.sv
logic/lsu_types_pkg.sv
logic/id_order_fifo.sv
logic/load_store_queue.sv
logic/lsu_data_ram.sv
logic/lsu_load_format.sv
logic/load_store_unit.sv
testbench/load_store_unit_tb.sv

// ==== logic/id_order_fifo.sv ====
`timescale 1ns/1ps

module id_order_fifo (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              push,
    input  logic [lsu_config_pkg::ID_WIDTH-1:0] push_id,
    input  logic                              pop,
    output logic [lsu_config_pkg::ID_WIDTH-1:0] head_id,
    output logic                              full,
    output logic                              empty
);
    import lsu_config_pkg::*;

    // ID storage, payload only
    logic [ID_WIDTH-1:0] id_mem [MAX_INFLIGHT_COUNT];

    logic [ID_WIDTH-1:0] wr_ptr;
    logic [ID_WIDTH-1:0] rd_ptr;
    // One extra bit so a full buffer is distinct from empty
    logic [ID_WIDTH:0] count;

    ////////////////////
    // Storage write
    always_ff @(posedge clk) begin
        if (push) begin
            id_mem[wr_ptr] <= push_id;
        end
    end

    ////////////////////
    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                // Wrap at the last slot
                if (wr_ptr == ID_WIDTH'(MAX_INFLIGHT_COUNT - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == ID_WIDTH'(MAX_INFLIGHT_COUNT - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // Simultaneous push and pop leaves count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Oldest ID, meaningless while empty
    assign head_id = id_mem[rd_ptr];
    assign full    = (count == (ID_WIDTH + 1)'(MAX_INFLIGHT_COUNT));
    assign empty   = (count == '0);

    ////////////////////
    // Checks on the queue side handshake
    push_not_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("ID FIFO push while full");

    pop_not_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("ID FIFO pop while empty");

endmodule

// ==== logic/load_store_queue.sv ====
`timescale 1ns/1ps

module load_store_queue (
    input  logic                                        clk,
    input  logic                                        rst,
    // Request in
    input  logic                                        req_valid,
    input  lsu_types_pkg::mem_op_e                      req_op,
    input  lsu_types_pkg::mem_fn3_e                     req_fn3,
    input  logic [lsu_config_pkg::ADDR_WIDTH-1:0]       req_addr,
    input  logic [31:0]                                 req_data,
    input  logic [lsu_config_pkg::ID_WIDTH-1:0]         req_id,
    input  logic                                        req_forwarded,
    input  logic [lsu_config_pkg::ID_WIDTH-1:0]         req_data_id,
    output logic                                        req_ready,
    // Writeback forwarding
    input  logic                                        writeback_valid,
    input  logic [31:0]                                 writeback_data,
    output logic                                        fwd_request,
    output logic [lsu_config_pkg::ID_WIDTH-1:0]         fwd_id,
    output logic [lsu_config_pkg::MAX_INFLIGHT_COUNT-1:0] hold_ids,
    // Issue to RAM and formatter
    output logic                                        issue_valid,
    output lsu_types_pkg::mem_op_e                      issue_op,
    output lsu_types_pkg::mem_fn3_e                     issue_fn3,
    output logic [lsu_config_pkg::ADDR_WIDTH-1:0]       issue_addr,
    output logic [3:0]                                  issue_be,
    output logic [31:0]                                 issue_data,
    output logic [lsu_config_pkg::ID_WIDTH-1:0]         issue_id
);
    import lsu_config_pkg::*;
    import lsu_types_pkg::*;

    // One table slot per instruction ID
    typedef struct packed {
        mem_op_e               op;
        mem_fn3_e              fn3;
        logic [ADDR_WIDTH-1:0] addr;
        logic [31:0]           data;
        logic                  forwarded;
        logic [ID_WIDTH-1:0]   data_id;
    } lsq_entry_t;

    lsq_entry_t entry_table [MAX_INFLIGHT_COUNT];
    lsq_entry_t head_entry;

    logic [MAX_INFLIGHT_COUNT-1:0] entry_valid;
    logic [MAX_INFLIGHT_COUNT-1:0] accept_oh;
    logic [MAX_INFLIGHT_COUNT-1:0] issue_oh;

    logic [HOLD_COUNT_WIDTH-1:0] hold_count_r    [MAX_INFLIGHT_COUNT];
    logic [HOLD_COUNT_WIDTH-1:0] hold_count_next [MAX_INFLIGHT_COUNT];

    logic                accept;
    logic                fifo_full;
    logic                fifo_empty;
    logic [ID_WIDTH-1:0] head_id;
    logic                head_valid;
    logic                fwd_complete;
    logic [31:0]         store_src;

    ////////////////////
    // Program order of IDs
    assign req_ready = !fifo_full;
    assign accept    = req_valid && req_ready;

    id_order_fifo order_fifo (
        .clk     (clk),
        .rst     (rst),
        .push    (accept),
        .push_id (req_id),
        .pop     (issue_valid),
        .head_id (head_id),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    // Request table, written at the incoming ID
    always_ff @(posedge clk) begin
        if (accept) begin
            entry_table[req_id] <= '{op: req_op, fn3: req_fn3, addr: req_addr,
                                     data: req_data, forwarded: req_forwarded,
                                     data_id: req_data_id};
        end
    end

    ////////////////////
    // Per ID valid bits
    always_comb begin
        accept_oh          = '0;
        accept_oh[req_id]  = accept;
        issue_oh           = '0;
        issue_oh[head_id]  = issue_valid;
    end

    // Clear before set so an ID reused in its issue cycle stays valid
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else begin
            entry_valid <= (entry_valid & ~issue_oh) | accept_oh;
        end
    end

    ////////////////////
    // Forwarded store hold counters
    assign fwd_complete = issue_valid && head_entry.forwarded;

    // Decrement applied to the incremented value, same ID cancels out
    always_comb begin
        hold_count_next = hold_count_r;
        if (accept && req_forwarded) begin
            hold_count_next[req_data_id] = hold_count_next[req_data_id] + 1'b1;
        end
        if (fwd_complete) begin
            hold_count_next[head_entry.data_id] = hold_count_next[head_entry.data_id] - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_count_r <= '{default: '0};
        end else begin
            hold_count_r <= hold_count_next;
        end
    end

    always_comb begin
        for (int i = 0; i < MAX_INFLIGHT_COUNT; i++) begin
            hold_ids[i] = (hold_count_r[i] != '0);
        end
    end

    ////////////////////
    // Head of queue and issue
    assign head_entry = entry_table[head_id];
    assign head_valid = !fifo_empty && entry_valid[head_id];

    // Forwarded head waits for its producer
    assign fwd_request = head_valid && head_entry.forwarded;
    assign fwd_id      = head_entry.data_id;
    assign issue_valid = head_valid && (!head_entry.forwarded || writeback_valid);

    assign issue_op   = head_entry.op;
    assign issue_fn3  = head_entry.fn3;
    assign issue_addr = head_entry.addr;
    assign issue_id   = head_id;

    assign store_src = head_entry.forwarded ? writeback_data : head_entry.data;

    // Copy low byte or halfword into every lane, enables pick the target
    always_comb begin
        case (head_entry.fn3)
            FN3_B, FN3_BU: begin
                issue_data = {4{store_src[7:0]}};
                issue_be   = 4'b0001 << head_entry.addr[1:0];
            end
            FN3_H, FN3_HU: begin
                issue_data = {2{store_src[15:0]}};
                issue_be   = head_entry.addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                issue_data = store_src;
                issue_be   = 4'b1111;
            end
        endcase
    end

    ////////////////////
    // Request stream checks
    // ID reuse only once the old entry has left
    id_not_in_flight: assert property (@(posedge clk) disable iff (rst)
        accept |-> (!entry_valid[req_id] || (issue_valid && head_id == req_id)))
        else $error("Request ID already in flight");

    aligned_request: assert property (@(posedge clk) disable iff (rst)
        accept |-> (((req_fn3 == FN3_H || req_fn3 == FN3_HU) -> !req_addr[0])
                    && ((req_fn3 == FN3_W) -> (req_addr[1:0] == 2'b00))))
        else $error("Misaligned request");

    hold_no_underflow: assert property (@(posedge clk) disable iff (rst)
        fwd_complete |-> (hold_count_r[head_entry.data_id] != '0
                          || (req_forwarded && accept && req_data_id == head_entry.data_id)))
        else $error("Hold counter decremented below zero");

endmodule

// ==== logic/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit (
    input  logic                                          clk,
    input  logic                                          rst,
    // Request in
    input  logic                                          req_valid,
    input  lsu_types_pkg::mem_op_e                        req_op,
    input  lsu_types_pkg::mem_fn3_e                       req_fn3,
    input  logic [lsu_config_pkg::ADDR_WIDTH-1:0]         req_addr,
    input  logic [31:0]                                   req_data,
    input  logic [lsu_config_pkg::ID_WIDTH-1:0]           req_id,
    input  logic                                          req_forwarded,
    input  logic [lsu_config_pkg::ID_WIDTH-1:0]           req_data_id,
    output logic                                          req_ready,
    // Forwarding
    output logic                                          fwd_request,
    output logic [lsu_config_pkg::ID_WIDTH-1:0]           fwd_id,
    input  logic                                          writeback_valid,
    input  logic [31:0]                                   writeback_data,
    output logic [lsu_config_pkg::MAX_INFLIGHT_COUNT-1:0] hold_ids,
    // Load result
    output logic                                          load_valid,
    output logic [lsu_config_pkg::ID_WIDTH-1:0]           load_id,
    output logic [31:0]                                   load_data
);
    import lsu_config_pkg::*;
    import lsu_types_pkg::*;

    ////////////////////
    // Issue path
    logic                issue_valid;
    mem_op_e             issue_op;
    mem_fn3_e            issue_fn3;
    logic [ADDR_WIDTH-1:0] issue_addr;
    logic [3:0]          issue_be;
    logic [31:0]         issue_data;
    logic [ID_WIDTH-1:0] issue_id;
    logic [31:0]         ram_rdata;
    logic                ram_wr_en;
    logic                ram_rd_en;

    // RAM strobes split by operation
    assign ram_wr_en = issue_valid && (issue_op == MEM_STORE);
    assign ram_rd_en = issue_valid && (issue_op == MEM_LOAD);

    load_store_queue lsq (
        .clk             (clk),
        .rst             (rst),
        .req_valid       (req_valid),
        .req_op          (req_op),
        .req_fn3         (req_fn3),
        .req_addr        (req_addr),
        .req_data        (req_data),
        .req_id          (req_id),
        .req_forwarded   (req_forwarded),
        .req_data_id     (req_data_id),
        .req_ready       (req_ready),
        .writeback_valid (writeback_valid),
        .writeback_data  (writeback_data),
        .fwd_request     (fwd_request),
        .fwd_id          (fwd_id),
        .hold_ids        (hold_ids),
        .issue_valid     (issue_valid),
        .issue_op        (issue_op),
        .issue_fn3       (issue_fn3),
        .issue_addr      (issue_addr),
        .issue_be        (issue_be),
        .issue_data      (issue_data),
        .issue_id        (issue_id)
    );

    // Word index from the byte address
    lsu_data_ram data_ram (
        .clk       (clk),
        .wr_en     (ram_wr_en),
        .rd_en     (ram_rd_en),
        .word_addr (issue_addr[ADDR_WIDTH-1:2]),
        .be        (issue_be),
        .wdata     (issue_data),
        .rdata     (ram_rdata)
    );

    lsu_load_format load_format (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_fn3   (issue_fn3),
        .issue_addr  (issue_addr),
        .issue_id    (issue_id),
        .rdata       (ram_rdata),
        .load_valid  (load_valid),
        .load_id     (load_id),
        .load_data   (load_data)
    );

endmodule

// ==== logic/lsu_config_pkg.sv ====
package lsu_config_pkg;

    ////////////////////
    // Sizes of the load/store front end

    // Distinct instruction IDs that can be in flight
    localparam int MAX_INFLIGHT_COUNT = 8;
    localparam int ID_WIDTH = 3;

    // Byte address space of the data RAM
    localparam int ADDR_WIDTH = 10;
    localparam int RAM_DEPTH_WORDS = 256;
    // Word index, byte offset dropped
    localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - 2;

    // Per producer count of waiting forwarded stores
    localparam int HOLD_COUNT_WIDTH = 4;

endpackage

// ==== logic/lsu_data_ram.sv ====
`timescale 1ns/1ps

module lsu_data_ram (
    input  logic                                       clk,
    input  logic                                       wr_en,
    input  logic                                       rd_en,
    input  logic [lsu_config_pkg::WORD_ADDR_WIDTH-1:0] word_addr,
    input  logic [3:0]                                 be,
    input  logic [31:0]                                wdata,
    output logic [31:0]                                rdata
);
    import lsu_config_pkg::*;

    // Word array, each lane written on its own enable
    logic [31:0] mem [RAM_DEPTH_WORDS];

    ////////////////////
    // Byte lane writes
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (be[lane]) begin
                    mem[word_addr][lane*8 +: 8] <= wdata[lane*8 +: 8];
                end
            end
        end
    end

    ////////////////////
    // Registered read
    // Output holds its last value between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[word_addr];
        end
    end

endmodule

// ==== logic/lsu_load_format.sv ====
`timescale 1ns/1ps

module lsu_load_format (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  issue_valid,
    input  lsu_types_pkg::mem_op_e                issue_op,
    input  lsu_types_pkg::mem_fn3_e               issue_fn3,
    input  logic [lsu_config_pkg::ADDR_WIDTH-1:0] issue_addr,
    input  logic [lsu_config_pkg::ID_WIDTH-1:0]   issue_id,
    input  logic [31:0]                           rdata,
    output logic                                  load_valid,
    output logic [lsu_config_pkg::ID_WIDTH-1:0]   load_id,
    output logic [31:0]                           load_data
);
    import lsu_config_pkg::*;
    import lsu_types_pkg::*;

    mem_fn3_e            fn3_r;
    logic [1:0]          offset_r;
    logic [ID_WIDTH-1:0] id_r;
    logic [31:0]         lane_data;

    ////////////////////
    // Issue attributes, aligned with the RAM read
    always_ff @(posedge clk) begin
        if (rst) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= issue_valid && (issue_op == MEM_LOAD);
        end
    end

    // Payload follows the RAM read, no reset needed
    always_ff @(posedge clk) begin
        fn3_r    <= issue_fn3;
        offset_r <= issue_addr[1:0];
        id_r     <= issue_id;
    end

    assign load_id = id_r;

    ////////////////////
    // Lane select and extension
    // Addressed byte or halfword moved to bit 0
    assign lane_data = rdata >> {offset_r, 3'b000};

    always_comb begin
        case (fn3_r)
            FN3_B:   load_data = {{24{lane_data[7]}}, lane_data[7:0]};
            FN3_BU:  load_data = {24'd0, lane_data[7:0]};
            FN3_H:   load_data = {{16{lane_data[15]}}, lane_data[15:0]};
            FN3_HU:  load_data = {16'd0, lane_data[15:0]};
            default: load_data = rdata;
        endcase
    end

endmodule

// ==== logic/lsu_types_pkg.sv ====
package lsu_types_pkg;

    ////////////////////
    // Operation encodings

    // Direction of a memory request
    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_op_e;

    // RISC-V funct3 access width
    // Bit 2 set means zero extension on loads
    // Low two bits give the size
    typedef enum logic [2:0] {
        FN3_B  = 3'd0,
        FN3_H  = 3'd1,
        FN3_W  = 3'd2,
        FN3_BU = 3'd4,
        FN3_HU = 3'd5
    } mem_fn3_e;

endpackage

// ==== testbench/load_store_unit_tb.sv ====
`timescale 1ns/1ps

module load_store_unit_tb;
    import lsu_config_pkg::*;
    import lsu_types_pkg::*;

    // One outstanding request as the model sees it
    typedef struct {
        logic [ID_WIDTH-1:0] id;
        logic                is_load;
        logic                forwarded;
        logic [ID_WIDTH-1:0] data_id;
        logic [31:0]         expected_data;
    } pending_t;

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          req_valid;
    mem_op_e                       req_op;
    mem_fn3_e                      req_fn3;
    logic [ADDR_WIDTH-1:0]         req_addr;
    logic [31:0]                   req_data;
    logic [ID_WIDTH-1:0]           req_id;
    logic                          req_forwarded;
    logic [ID_WIDTH-1:0]           req_data_id;
    logic                          req_ready;
    logic                          fwd_request;
    logic [ID_WIDTH-1:0]           fwd_id;
    logic                          writeback_valid;
    logic [31:0]                   writeback_data;
    logic [MAX_INFLIGHT_COUNT-1:0] hold_ids;
    logic                          load_valid;
    logic [ID_WIDTH-1:0]           load_id;
    logic [31:0]                   load_data;

    // Model state
    logic [7:0]          model_mem [RAM_DEPTH_WORDS*4];
    pending_t            pending [$];
    logic [ID_WIDTH-1:0] free_ids [$];
    int                  hold_count [MAX_INFLIGHT_COUNT];
    logic [31:0]         producer_value [MAX_INFLIGHT_COUNT];

    logic [15:0] lfsr_state;
    logic        responder_stalled;
    logic        wb_armed;
    logic [1:0]  wb_delay;
    string       test_name = "reset";
    int          wait_limit = 1000;

    load_store_unit DUT (.*);

    always #20 clk = ~clk;

    ////////////////////
    // Random source
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic next_random_bit();
        logic feedback;
        feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] random_bits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], next_random_bit()};
        end
        return value;
    endfunction

    // Stores only use the three RISC-V store widths
    function automatic mem_fn3_e pick_fn3(logic is_load);
        logic [31:0] sel;
        sel = random_bits(3) % (is_load ? 5 : 3);
        case (sel)
            0:       return FN3_B;
            1:       return FN3_H;
            2:       return FN3_W;
            3:       return FN3_BU;
            default: return FN3_HU;
        endcase
    endfunction

    ////////////////////
    // Memory model
    function automatic logic [31:0] expected_load(logic [ADDR_WIDTH-1:0] addr, mem_fn3_e fn3);
        logic [15:0] half;
        half = (fn3 == FN3_H || fn3 == FN3_HU) ? {model_mem[addr + 1], model_mem[addr]} : '0;
        case (fn3)
            FN3_B:   return {{24{model_mem[addr][7]}}, model_mem[addr]};
            FN3_BU:  return {24'd0, model_mem[addr]};
            FN3_H:   return {{16{half[15]}}, half};
            FN3_HU:  return {16'd0, half};
            default: return {model_mem[addr + 3], model_mem[addr + 2],
                             model_mem[addr + 1], model_mem[addr]};
        endcase
    endfunction

    // Low bytes of the data, starting at the byte address
    function automatic void apply_store(logic [ADDR_WIDTH-1:0] addr, mem_fn3_e fn3,
                                        logic [31:0] data);
        int size;
        size = (fn3 == FN3_W) ? 4 : ((fn3 == FN3_H || fn3 == FN3_HU) ? 2 : 1);
        for (int i = 0; i < size; i++) begin
            model_mem[addr + i] = data[8*i +: 8];
        end
    endfunction

    function automatic logic [31:0] fill_pattern(logic [7:0] w);
        return {w, ~w, w ^ 8'h5a, w + 8'h3c};
    endfunction

    function automatic logic [MAX_INFLIGHT_COUNT-1:0] expected_hold_mask();
        logic [MAX_INFLIGHT_COUNT-1:0] mask;
        for (int i = 0; i < MAX_INFLIGHT_COUNT; i++) begin
            mask[i] = (hold_count[i] != 0);
        end
        return mask;
    endfunction

    ////////////////////
    // Failure reporting
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s %s expected 0x%08h actual 0x%08h",
                     test_name, what, expected, actual);
            abort_run("Response mismatch");
        end
    endtask

    ////////////////////
    // Scoreboard
    // Plain stores ahead of the completing request have already issued
    task automatic pop_issued(output pending_t entry);
        if (pending.size() == 0) begin
            abort_run("DUT completed a request that was never accepted");
        end
        entry = pending.pop_front();
        while (!entry.is_load && !entry.forwarded) begin
            free_ids.push_back(entry.id);
            if (pending.size() == 0) begin
                abort_run("DUT completed a request that was never accepted");
            end
            entry = pending.pop_front();
        end
    endtask

    // Stores land in the model at acceptance, loads capture their result then
    task automatic record_accept();
        pending_t    entry;
        logic [31:0] store_data;
        entry.id            = req_id;
        entry.is_load       = (req_op == MEM_LOAD);
        entry.forwarded     = (req_op == MEM_STORE) && req_forwarded;
        entry.data_id       = req_data_id;
        entry.expected_data = '0;
        if (entry.is_load) begin
            entry.expected_data = expected_load(req_addr, req_fn3);
        end else begin
            store_data = req_forwarded ? producer_value[req_data_id] : req_data;
            apply_store(req_addr, req_fn3, store_data);
            if (req_forwarded) begin
                hold_count[req_data_id] = hold_count[req_data_id] + 1;
            end
        end
        pending.push_back(entry);
    endtask

    always @(posedge clk) begin : scoreboard
        pending_t entry;
        if (!rst) begin
            check_equal("hold_ids", expected_hold_mask(), hold_ids);
            if (load_valid) begin
                pop_issued(entry);
                if (!entry.is_load) begin
                    abort_run("Load returned while an older forwarded store had not issued");
                end
                check_equal("load_id", entry.id, load_id);
                check_equal("load_data", entry.expected_data, load_data);
                free_ids.push_back(entry.id);
            end
            if (fwd_request && writeback_valid) begin
                pop_issued(entry);
                if (entry.is_load) begin
                    abort_run("Forwarded store issued ahead of an older load");
                end
                check_equal("fwd_id", entry.data_id, fwd_id);
                hold_count[entry.data_id] = hold_count[entry.data_id] - 1;
                free_ids.push_back(entry.id);
            end
            if (req_valid && req_ready) begin
                record_accept();
            end
        end
    end

    ////////////////////
    // Writeback responder
    // Answers a forwarding request after 0 to 3 extra cycles
    always @(posedge clk) begin
        if (rst) begin
            writeback_valid <= 1'b0;
            wb_armed        <= 1'b0;
        end else if (writeback_valid && fwd_request) begin
            writeback_valid <= 1'b0;
            wb_armed        <= 1'b0;
        end else if (fwd_request && !responder_stalled && !writeback_valid) begin
            if (!wb_armed) begin
                wb_delay <= 2'(random_bits(2));
                wb_armed <= 1'b1;
            end else if (wb_delay == 0) begin
                writeback_valid <= 1'b1;
                writeback_data  <= producer_value[fwd_id];
            end else begin
                wb_delay <= wb_delay - 1'b1;
            end
        end
    end

    ////////////////////
    // Request driver
    // Free list only changes on rising edges, so look at it on falling ones
    task automatic wait_for_free_id();
        int waited;
        waited = 0;
        @(negedge clk);
        while (free_ids.size() == 0) begin
            waited++;
            if (waited > wait_limit) begin
                abort_run("Timeout waiting for a free instruction ID");
            end
            @(negedge clk);
        end
    endtask

    task automatic drive_request(input mem_op_e op, input mem_fn3_e fn3,
                                 input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                                 input logic forwarded, input logic [ID_WIDTH-1:0] data_id);
        int waited;
        waited = 0;
        @(posedge clk);
        req_valid     <= 1'b1;
        req_op        <= op;
        req_fn3       <= fn3;
        req_addr      <= addr;
        req_data      <= data;
        req_id        <= free_ids.pop_front();
        req_forwarded <= forwarded;
        req_data_id   <= data_id;
        @(posedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > wait_limit) begin
                abort_run("Timeout waiting for req_ready");
            end
            @(posedge clk);
        end
        req_valid <= 1'b0;
    endtask

    task automatic send_random_request();
        mem_op_e               op;
        mem_fn3_e              fn3;
        logic [ADDR_WIDTH-1:0] addr;
        wait_for_free_id();
        op = next_random_bit() ? MEM_STORE : MEM_LOAD;
        // Last free ID goes to a load, which retires every store before it
        if (op == MEM_STORE && free_ids.size() < 2) begin
            op = MEM_LOAD;
        end
        fn3  = pick_fn3(op == MEM_LOAD);
        addr = ADDR_WIDTH'(random_bits(ADDR_WIDTH));
        if (fn3 == FN3_W) begin
            addr[1:0] = 2'b00;
        end else if (fn3 == FN3_H || fn3 == FN3_HU) begin
            addr[0] = 1'b0;
        end
        drive_request(op, fn3, addr, random_bits(32),
                      (op == MEM_STORE) && (random_bits(2) == 0),
                      ID_WIDTH'(random_bits(ID_WIDTH)));
    endtask

    // Trailing load flushes stores, then wait for the model to empty
    task automatic drain_queue();
        int waited;
        waited = 0;
        wait_for_free_id();
        drive_request(MEM_LOAD, FN3_W, '0, '0, 1'b0, '0);
        @(negedge clk);
        while (pending.size() != 0) begin
            waited++;
            if (waited > wait_limit) begin
                abort_run("Timeout waiting for outstanding requests to complete");
            end
            @(negedge clk);
        end
    endtask

    ////////////////////
    // Test sequence
    initial begin
        int waited;
        req_valid         = 1'b0;
        req_op            = MEM_LOAD;
        req_fn3           = FN3_W;
        req_addr          = '0;
        req_data          = '0;
        req_id            = '0;
        req_forwarded     = 1'b0;
        req_data_id       = '0;
        writeback_valid   = 1'b0;
        writeback_data    = '0;
        rst               = 1'b1;
        responder_stalled = 1'b0;
        lfsr_state        = 16'd47;
        for (int i = 0; i < MAX_INFLIGHT_COUNT; i++) begin
            producer_value[i] = random_bits(32);
            hold_count[i]     = 0;
            free_ids.push_back(ID_WIDTH'(i));
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Idle outputs right after reset
        @(posedge clk);
        check_equal("load_valid", 0, load_valid);
        check_equal("fwd_request", 0, fwd_request);
        check_equal("hold_ids", 0, hold_ids);
        check_equal("req_ready", 1, req_ready);

        // Whole RAM written and read back as words
        test_name = "fill";
        for (int w = 0; w < RAM_DEPTH_WORDS; w++) begin
            wait_for_free_id();
            drive_request(MEM_STORE, FN3_W, {w[7:0], 2'b00}, fill_pattern(w[7:0]), 1'b0, '0);
            wait_for_free_id();
            drive_request(MEM_LOAD, FN3_W, {w[7:0], 2'b00}, '0, 1'b0, '0);
        end
        drain_queue();

        // Mixed widths, offsets and forwarded stores
        test_name = "random";
        for (int n = 0; n < 400; n++) begin
            send_random_request();
        end
        drain_queue();

        // Forwarded store blocks the head while the queue fills up
        test_name = "backpressure";
        responder_stalled <= 1'b1;
        wait_for_free_id();
        drive_request(MEM_STORE, FN3_H, 10'h102, '0, 1'b1, ID_WIDTH'(random_bits(ID_WIDTH)));
        wait_for_free_id();
        drive_request(MEM_LOAD, FN3_HU, 10'h102, '0, 1'b0, '0);
        for (int n = 0; n < MAX_INFLIGHT_COUNT - 2; n++) begin
            wait_for_free_id();
            drive_request(MEM_LOAD, FN3_BU, ADDR_WIDTH'(random_bits(ADDR_WIDTH)), '0, 1'b0, '0);
        end
        waited = 0;
        @(posedge clk);
        while (req_ready) begin
            waited++;
            if (waited > wait_limit) begin
                abort_run("Timeout waiting for req_ready to fall with a full queue");
            end
            @(posedge clk);
        end
        // Ninth request must not be taken
        req_valid <= 1'b1;
        req_op    <= MEM_LOAD;
        req_fn3   <= FN3_W;
        repeat (4) begin
            @(posedge clk);
            check_equal("req_ready", 0, req_ready);
        end
        req_valid         <= 1'b0;
        responder_stalled <= 1'b0;
        for (int n = 0; n < 100; n++) begin
            send_random_request();
        end
        drain_queue();

        $display("Finished with no errors");
        $finish;
    end

endmodule
